// File: flist.f
source/cu_pkg.sv
source/instr_sequencer.sv
source/instr_classifier.sv
source/branch_resolver.sv
source/datapath_ctrl.sv
source/memory_ctrl.sv
source/cu_top.sv
bench/cu_asserts.sv
bench/tb_cu.sv

// File: bench/tb_cu.sv
`timescale 1ns/1ps

module tb_cu;

	localparam int RESET_CYCLES = 10;
	localparam int DIRECTED_CYCLES = 34; // Reset release plus directed bytes
	localparam int RANDOM_CYCLES = 400;
	localparam int WATCHDOG_NS = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 20) * 10;

	logic clk;
	logic rst;
	logic [cu_pkg::INSTR_W-1:0] opcode;
	logic [cu_pkg::FLAGS_W-1:0] flags;
	logic intr_in;
	logic [cu_pkg::REG_SEL_W-1:0] old_rb;
	cu_pkg::rdata_sel_e rdata_sel;
	cu_pkg::dmem_wd_sel_e dmem_wd_sel;
	cu_pkg::dmem_a_sel_e dmem_a_sel;
	logic mux_out_sel;
	cu_pkg::pc_sel_e pc_sel;
	cu_pkg::addr_sel_e addr_sel;
	logic branch_taken;
	logic f_save;
	logic f_restore;
	logic sp_sel;
	logic rd2_sel;
	logic wr_en_dmem;
	logic rd_en;
	logic wr_en_regf;
	logic is_ret;
	cu_pkg::alu_op_e alu_control;
	int unsigned rng_state;

	cu_top dut_i (.*);

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic drive_cycle(input logic [7:0] b, input logic [3:0] f, input logic irq);
		@(negedge clk);
		opcode = b;
		flags = f;
		intr_in = irq;
	endtask

	task automatic drive_random();
		rng_state = lcg_next(rng_state);
		drive_cycle(rng_state[23:16], rng_state[11:8], rng_state[30:28] == 3'd0); // Rare interrupt
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		int r;
		int unsigned errors;
		rst = 1'b0;
		opcode = '0;
		flags = '0;
		intr_in = 1'b0;
		rng_state = 32'd90419;
		repeat (RESET_CYCLES) drive_random(); // Decode must stay on the reset vector
		@(negedge clk);
		rst = 1'b1;
		opcode = '0;
		intr_in = 1'b0;

		// LDM, LDD, STD and the unused slot; interrupt on the second byte is ignored
		for (r = 0; r < 4; r++) begin
			drive_cycle({4'hC, r[1:0], r[1:0]}, 4'h0, 1'b0);
			drive_cycle(8'h5A, 4'hF, r[0]);
		end
		for (r = 0; r < 4; r++) begin
			drive_cycle({4'h9, r[1:0], 2'b01}, 4'b1000 >> r, 1'b0); // Only the tested flag set
			drive_cycle({4'h9, r[1:0], 2'b01}, ~(4'b1000 >> r), 1'b0);
		end
		drive_cycle(8'h70, 4'h0, 1'b0); // PUSH
		drive_cycle(8'h74, 4'h0, 1'b0); // POP
		drive_cycle(8'hB4, 4'h0, 1'b0); // CALL
		drive_cycle(8'hB8, 4'h0, 1'b0); // RET
		drive_cycle(8'hBC, 4'h0, 1'b0); // RTI
		drive_cycle(8'h10, 4'h0, 1'b1);
		for (r = 1; r < 6; r++) begin
			drive_cycle({r[3:0], 4'h6}, 4'h0, 1'b0);
		end
		for (r = 0; r < 4; r++) begin
			drive_cycle({4'h8, r[1:0], 2'b10}, 4'h0, 1'b0);
		end
		drive_cycle(8'hC3, 4'h0, 1'b1); // Interrupt beats the two-byte group
		drive_cycle(8'h70, 4'h0, 1'b0);

		repeat (RANDOM_CYCLES) drive_random();
		@(negedge clk);
		@(negedge clk);
		errors = dut_i.chk_i.err_count;
		$display("Closing report: %0d assertion failures", errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: bench/cu_asserts.sv
`timescale 1ns/1ps

module cu_asserts (
	input logic clk,
	input logic rst,
	input logic [cu_pkg::INSTR_W-1:0] opcode,
	input logic [cu_pkg::FLAGS_W-1:0] flags,
	input logic intr_in,
	input logic [cu_pkg::REG_SEL_W-1:0] old_rb,
	input cu_pkg::rdata_sel_e rdata_sel,
	input cu_pkg::dmem_wd_sel_e dmem_wd_sel,
	input cu_pkg::dmem_a_sel_e dmem_a_sel,
	input logic mux_out_sel,
	input cu_pkg::pc_sel_e pc_sel,
	input cu_pkg::addr_sel_e addr_sel,
	input logic branch_taken,
	input logic f_save,
	input logic f_restore,
	input logic sp_sel,
	input logic rd2_sel,
	input logic wr_en_dmem,
	input logic rd_en,
	input logic wr_en_regf,
	input logic is_ret,
	input cu_pkg::alu_op_e alu_control
);

	int unsigned err_count = 0; // Read by the testbench at the end
	logic exp_second; // Expected SECOND_BYTE phase
	logic [cu_pkg::INSTR_W-1:0] exp_held;
	logic [3:0] major;
	logic [1:0] ra;
	logic idle_ok; // Current byte decoded from the table
	logic intr_ok; // Interrupt entry this cycle
	logic [4:0] enables;

	assign major = opcode[7:4];
	assign ra = opcode[3:2];
	assign idle_ok = rst && !exp_second && !intr_in;
	assign intr_ok = rst && !exp_second && intr_in;
	assign enables = {wr_en_regf, wr_en_dmem, rd_en, f_save, f_restore};

	// Two-byte fetch model
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			exp_second <= 1'b0;
			exp_held <= '0;
		end else if (idle_ok && major == 4'd12) begin
			exp_second <= 1'b1;
			exp_held <= opcode;
		end else begin
			exp_second <= 1'b0;
		end
	end

	function automatic logic cond_flag(input logic [3:0] f, input logic [1:0] sel);
		case (sel)
			2'd0: return f[cu_pkg::FLAG_Z];
			2'd1: return f[cu_pkg::FLAG_N];
			2'd2: return f[cu_pkg::FLAG_C];
			default: return f[cu_pkg::FLAG_V];
		endcase
	endfunction

	function automatic cu_pkg::alu_op_e alu_code_for(input logic [3:0] maj, input logic [1:0] sel);
		case (maj)
			4'd1: return cu_pkg::ALU_MOV;
			4'd2: return cu_pkg::ALU_ADD;
			4'd3: return cu_pkg::ALU_SUB;
			4'd4: return cu_pkg::ALU_AND;
			4'd5: return cu_pkg::ALU_OR;
			4'd8: begin
				case (sel)
					2'd0: return cu_pkg::ALU_NOT;
					2'd1: return cu_pkg::ALU_NEG;
					2'd2: return cu_pkg::ALU_INC;
					default: return cu_pkg::ALU_DEC;
				endcase
			end
			default: return cu_pkg::ALU_NOP;
		endcase
	endfunction

	a_reset_pc: assert property (@(posedge clk) !rst |-> pc_sel == cu_pkg::PC_RESET_VEC)
		else begin
			err_count++;
			$error("MISMATCH reset_pc expected %0d actual %0d",
				cu_pkg::PC_RESET_VEC, $sampled(pc_sel));
		end
	a_reset_en: assert property (@(posedge clk) !rst |-> enables == 5'b0)
		else begin
			err_count++;
			$error("MISMATCH reset_enables expected %b actual %b",
				5'b0, $sampled(enables));
		end
	a_fetch2: assert property (@(posedge clk) disable iff (!rst)
		idle_ok && major == 4'd12 |-> enables == 5'b0 && pc_sel == cu_pkg::PC_INC)
		else begin
			err_count++;
			$error("MISMATCH fetch2_ctrl expected %b actual %b",
				{5'b0, cu_pkg::PC_INC}, $sampled({enables, pc_sel}));
		end
	a_old_rb_hold: assert property (@(posedge clk) disable iff (!rst)
		exp_second |-> old_rb == exp_held[1:0])
		else begin
			err_count++;
			$error("MISMATCH old_rb_hold expected %0d actual %0d",
				$sampled(exp_held[1:0]), $sampled(old_rb));
		end
	a_old_rb_idle: assert property (@(posedge clk) disable iff (!rst) !exp_second |-> old_rb == 0)
		else begin
			err_count++;
			$error("MISMATCH old_rb_idle expected 0 actual %0d", $sampled(old_rb));
		end
	a_ldm: assert property (@(posedge clk) disable iff (!rst) exp_second && exp_held[3:2] == 2'd0
		|-> {rdata_sel, addr_sel, wr_en_regf} == {cu_pkg::RDATA_IMM, cu_pkg::WA_OLD_RB, 1'b1})
		else begin
			err_count++;
			$error("MISMATCH ldm_ctrl expected %b actual %b",
				{cu_pkg::RDATA_IMM, cu_pkg::WA_OLD_RB, 1'b1},
				$sampled({rdata_sel, addr_sel, wr_en_regf}));
		end
	a_ldd: assert property (@(posedge clk) disable iff (!rst) exp_second && exp_held[3:2] == 2'd1
		|-> {rd_en, dmem_a_sel} == {1'b1, cu_pkg::DA_EA})
		else begin
			err_count++;
			$error("MISMATCH ldd_ctrl expected %b actual %b",
				{1'b1, cu_pkg::DA_EA}, $sampled({rd_en, dmem_a_sel}));
		end
	a_std: assert property (@(posedge clk) disable iff (!rst) exp_second && exp_held[3:2] == 2'd2
		|-> {wr_en_dmem, rd2_sel} == 2'b11)
		else begin
			err_count++;
			$error("MISMATCH std_ctrl expected %b actual %b",
				2'b11, $sampled({wr_en_dmem, rd2_sel}));
		end
	a_jcond_taken: assert property (@(posedge clk) disable iff (!rst)
		idle_ok && major == 4'd9 |-> branch_taken == cond_flag(flags, ra))
		else begin
			err_count++;
			$error("MISMATCH jcond_taken expected %b actual %b",
				cond_flag($sampled(flags), $sampled(ra)), $sampled(branch_taken));
		end
	a_jcond_pc: assert property (@(posedge clk) disable iff (!rst) idle_ok && major == 4'd9
		|-> pc_sel == (cond_flag(flags, ra) ? cu_pkg::PC_JUMP : cu_pkg::PC_INC))
		else begin
			err_count++;
			$error("MISMATCH jcond_pc expected %0d actual %0d",
				cond_flag($sampled(flags), $sampled(ra)) ? cu_pkg::PC_JUMP : cu_pkg::PC_INC,
				$sampled(pc_sel));
		end
	a_jcond_mux: assert property (@(posedge clk) disable iff (!rst)
		idle_ok && major == 4'd9 |-> mux_out_sel == cond_flag(flags, ra)) // ALU path when taken
		else begin
			err_count++;
			$error("MISMATCH jcond_mux expected %b actual %b",
				cond_flag($sampled(flags), $sampled(ra)), $sampled(mux_out_sel));
		end
	a_stack_wr: assert property (@(posedge clk) disable iff (!rst)
		(idle_ok && ((major == 4'd7 && ra == 2'd0) || (major == 4'd11 && ra == 2'd1))) || intr_ok
		|-> {wr_en_dmem, sp_sel} == 2'b10) // PUSH, CALL, interrupt
		else begin
			err_count++;
			$error("MISMATCH stack_write expected %b actual %b",
				2'b10, $sampled({wr_en_dmem, sp_sel}));
		end
	a_push_wd: assert property (@(posedge clk) disable iff (!rst)
		idle_ok && major == 4'd7 && ra == 2'd0 |-> dmem_wd_sel == cu_pkg::WD_REG)
		else begin
			err_count++;
			$error("MISMATCH push_wdata expected %0d actual %0d",
				cu_pkg::WD_REG, $sampled(dmem_wd_sel));
		end
	a_call_wd: assert property (@(posedge clk) disable iff (!rst)
		idle_ok && major == 4'd11 && ra == 2'd1 |-> dmem_wd_sel == cu_pkg::WD_PC_NEXT)
		else begin
			err_count++;
			$error("MISMATCH call_wdata expected %0d actual %0d",
				cu_pkg::WD_PC_NEXT, $sampled(dmem_wd_sel));
		end
	a_stack_rd: assert property (@(posedge clk) disable iff (!rst)
		idle_ok && ((major == 4'd7 && ra == 2'd1) || (major == 4'd11 && ra >= 2'd2))
		|-> {rd_en, sp_sel} == 2'b11) // POP, RET, RTI
		else begin
			err_count++;
			$error("MISMATCH stack_read expected %b actual %b",
				2'b11, $sampled({rd_en, sp_sel}));
		end
	a_is_ret: assert property (@(posedge clk) disable iff (!rst)
		is_ret == (idle_ok && major == 4'd11 && ra >= 2'd2))
		else begin
			err_count++;
			$error("MISMATCH is_ret expected %b actual %b",
				$sampled(idle_ok && major == 4'd11 && ra >= 2'd2), $sampled(is_ret));
		end
	a_f_save: assert property (@(posedge clk) disable iff (!rst) f_save == intr_ok)
		else begin
			err_count++;
			$error("MISMATCH f_save expected %b actual %b",
				$sampled(intr_ok), $sampled(f_save));
		end
	a_f_restore: assert property (@(posedge clk) disable iff (!rst)
		f_restore == (idle_ok && major == 4'd11 && ra == 2'd3))
		else begin
			err_count++;
			$error("MISMATCH f_restore expected %b actual %b",
				$sampled(idle_ok && major == 4'd11 && ra == 2'd3), $sampled(f_restore));
		end
	a_alu_code: assert property (@(posedge clk) disable iff (!rst)
		idle_ok && major inside {[4'd1:4'd5], 4'd8}
		|-> alu_control == alu_code_for(major, ra) && wr_en_regf)
		else begin
			err_count++;
			$error("MISMATCH alu_code expected %0d/1 actual %0d/%0d",
				alu_code_for($sampled(major), $sampled(ra)), $sampled(alu_control),
				$sampled(wr_en_regf));
		end
	a_intr_ctrl: assert property (@(posedge clk) disable iff (!rst) intr_ok
		|-> pc_sel == cu_pkg::PC_INTR_VEC && alu_control == cu_pkg::ALU_INTR &&
			dmem_wd_sel == cu_pkg::WD_PC)
		else begin
			err_count++;
			$error("MISMATCH intr_ctrl expected %0d/%0d/%0d actual %0d/%0d/%0d",
				cu_pkg::PC_INTR_VEC, cu_pkg::ALU_INTR, cu_pkg::WD_PC, $sampled(pc_sel),
				$sampled(alu_control), $sampled(dmem_wd_sel));
		end
	a_intr_no_capture: assert property (@(posedge clk) disable iff (!rst)
		intr_ok && major == 4'd12 |=> old_rb == 0) // Next byte is decoded fresh
		else begin
			err_count++;
			$error("MISMATCH intr_no_capture expected 0 actual %0d", $sampled(old_rb));
		end

endmodule

bind cu_top cu_asserts chk_i (.*);

// File: source/cu_top.sv
`timescale 1ns/1ps

module cu_top (
	input logic clk,
	input logic rst,
	input logic [cu_pkg::INSTR_W-1:0] opcode,
	input logic [cu_pkg::FLAGS_W-1:0] flags, // {Z, N, C, V}
	input logic intr_in,
	output logic [cu_pkg::REG_SEL_W-1:0] old_rb,
	output cu_pkg::rdata_sel_e rdata_sel,
	output cu_pkg::dmem_wd_sel_e dmem_wd_sel,
	output cu_pkg::dmem_a_sel_e dmem_a_sel,
	output logic mux_out_sel,
	output cu_pkg::pc_sel_e pc_sel,
	output cu_pkg::addr_sel_e addr_sel,
	output logic branch_taken,
	output logic f_save,
	output logic f_restore,
	output logic sp_sel,
	output logic rd2_sel,
	output logic wr_en_dmem,
	output logic rd_en,
	output logic wr_en_regf,
	output logic is_ret,
	output cu_pkg::alu_op_e alu_control
);

	cu_pkg::state_e phase;
	logic [cu_pkg::INSTR_W-1:0] held_byte;
	cu_pkg::cmd_e cmd; // One decoded command per cycle

	instr_sequencer seq_i (.clk(clk), .rst(rst), .opcode(opcode), .intr_in(intr_in),
		.phase(phase), .held_byte(held_byte), .old_rb(old_rb));

	instr_classifier cls_i (.rst(rst), .intr_in(intr_in), .phase(phase), .opcode(opcode),
		.held_byte(held_byte), .cmd(cmd));

	branch_resolver br_i (.cmd(cmd), .flags(flags), .pc_sel(pc_sel), .taken(branch_taken),
		.is_ret(is_ret));

	datapath_ctrl dp_i (.cmd(cmd), .taken(branch_taken), .alu_control(alu_control),
		.mux_out_sel(mux_out_sel), .wr_en_regf(wr_en_regf), .rd2_sel(rd2_sel),
		.addr_sel(addr_sel), .rdata_sel(rdata_sel));

	memory_ctrl mem_i (.cmd(cmd), .wr_en_dmem(wr_en_dmem), .rd_en(rd_en), .sp_sel(sp_sel),
		.f_save(f_save), .f_restore(f_restore), .dmem_a_sel(dmem_a_sel),
		.dmem_wd_sel(dmem_wd_sel));

endmodule

// File: source/memory_ctrl.sv
`timescale 1ns/1ps

module memory_ctrl (
	input cu_pkg::cmd_e cmd,
	output logic wr_en_dmem,
	output logic rd_en,
	output logic sp_sel, // 1 increments SP, 0 decrements
	output logic f_save,
	output logic f_restore,
	output cu_pkg::dmem_a_sel_e dmem_a_sel,
	output cu_pkg::dmem_wd_sel_e dmem_wd_sel
);

	always_comb begin
		wr_en_dmem = 1'b0;
		rd_en = 1'b0;
		sp_sel = 1'b0;
		f_save = 1'b0;
		f_restore = 1'b0;
		dmem_a_sel = cu_pkg::DA_REG;
		dmem_wd_sel = cu_pkg::WD_ZERO;
		case (cmd)
			cu_pkg::CMD_PUSH,
			cu_pkg::CMD_CALL,
			cu_pkg::CMD_INTR: begin
				wr_en_dmem = 1'b1;
				dmem_a_sel = cu_pkg::DA_SP; // Post-decrement push
				case (cmd)
					cu_pkg::CMD_PUSH: dmem_wd_sel = cu_pkg::WD_REG;
					cu_pkg::CMD_CALL: dmem_wd_sel = cu_pkg::WD_PC_NEXT; // Return address
					default: dmem_wd_sel = cu_pkg::WD_PC; // Interrupted PC
				endcase
				f_save = (cmd == cu_pkg::CMD_INTR);
			end
			cu_pkg::CMD_POP,
			cu_pkg::CMD_RET,
			cu_pkg::CMD_RTI: begin
				rd_en = 1'b1;
				sp_sel = 1'b1;
				dmem_a_sel = cu_pkg::DA_SP_INC; // Pre-increment pop
				f_restore = (cmd == cu_pkg::CMD_RTI);
			end
			cu_pkg::CMD_LDI: rd_en = 1'b1; // Address from R[ra]
			cu_pkg::CMD_STI: begin
				wr_en_dmem = 1'b1;
				dmem_wd_sel = cu_pkg::WD_REG;
			end
			cu_pkg::CMD_LDD: begin
				rd_en = 1'b1;
				dmem_a_sel = cu_pkg::DA_EA;
			end
			cu_pkg::CMD_STD: begin
				wr_en_dmem = 1'b1;
				dmem_a_sel = cu_pkg::DA_EA; // Effective address from second byte
				dmem_wd_sel = cu_pkg::WD_REG;
			end
			default: begin
			end
		endcase
	end

endmodule

// File: source/datapath_ctrl.sv
`timescale 1ns/1ps

module datapath_ctrl (
	input cu_pkg::cmd_e cmd,
	input logic taken,
	output cu_pkg::alu_op_e alu_control,
	output logic mux_out_sel,
	output logic wr_en_regf,
	output logic rd2_sel,
	output cu_pkg::addr_sel_e addr_sel,
	output cu_pkg::rdata_sel_e rdata_sel
);

	always_comb begin
		alu_control = cu_pkg::ALU_NOP;
		mux_out_sel = 1'b0; // Memory data unless ALU chosen
		wr_en_regf = 1'b0;
		rd2_sel = 1'b0;
		addr_sel = cu_pkg::WA_RA;
		rdata_sel = cu_pkg::RDATA_SP;
		case (cmd)
			cu_pkg::CMD_MOV,
			cu_pkg::CMD_ADD,
			cu_pkg::CMD_SUB,
			cu_pkg::CMD_AND,
			cu_pkg::CMD_OR: begin
				case (cmd)
					cu_pkg::CMD_MOV: alu_control = cu_pkg::ALU_MOV;
					cu_pkg::CMD_ADD: alu_control = cu_pkg::ALU_ADD;
					cu_pkg::CMD_SUB: alu_control = cu_pkg::ALU_SUB;
					cu_pkg::CMD_AND: alu_control = cu_pkg::ALU_AND;
					default: alu_control = cu_pkg::ALU_OR;
				endcase
				mux_out_sel = 1'b1;
				rdata_sel = cu_pkg::RDATA_RESULT;
				wr_en_regf = 1'b1; // Result to R[ra]
			end
			cu_pkg::CMD_RLC,
			cu_pkg::CMD_RRC,
			cu_pkg::CMD_NOT,
			cu_pkg::CMD_NEG,
			cu_pkg::CMD_INC,
			cu_pkg::CMD_DEC: begin
				case (cmd)
					cu_pkg::CMD_RLC: alu_control = cu_pkg::ALU_ROT_L;
					cu_pkg::CMD_RRC: alu_control = cu_pkg::ALU_ROT_R;
					cu_pkg::CMD_NOT: alu_control = cu_pkg::ALU_NOT;
					cu_pkg::CMD_NEG: alu_control = cu_pkg::ALU_NEG;
					cu_pkg::CMD_INC: alu_control = cu_pkg::ALU_INC;
					default: alu_control = cu_pkg::ALU_DEC;
				endcase
				mux_out_sel = 1'b1;
				rdata_sel = cu_pkg::RDATA_RESULT;
				addr_sel = cu_pkg::WA_RB; // Single-operand ops write R[rb]
				wr_en_regf = 1'b1;
			end
			cu_pkg::CMD_SETC: alu_control = cu_pkg::ALU_SETC;
			cu_pkg::CMD_CLRC: alu_control = cu_pkg::ALU_CLRC;
			cu_pkg::CMD_PUSH: alu_control = cu_pkg::ALU_ROT_L;
			cu_pkg::CMD_POP: begin
				alu_control = cu_pkg::ALU_ROT_R;
				rdata_sel = cu_pkg::RDATA_RESULT;
				addr_sel = cu_pkg::WA_RB; // Popped data into R[rb]
				wr_en_regf = 1'b1;
			end
			cu_pkg::CMD_JZ,
			cu_pkg::CMD_JN,
			cu_pkg::CMD_JC,
			cu_pkg::CMD_JV: begin
				case (cmd)
					cu_pkg::CMD_JZ: alu_control = cu_pkg::ALU_JZ;
					cu_pkg::CMD_JN: alu_control = cu_pkg::ALU_JN;
					cu_pkg::CMD_JC: alu_control = cu_pkg::ALU_JC;
					default: alu_control = cu_pkg::ALU_JV;
				endcase
				if (taken) begin
					alu_control = cu_pkg::ALU_PASS_RD2; // Jump target from R[rb]
					mux_out_sel = 1'b1;
				end
			end
			cu_pkg::CMD_LOOP: begin
				alu_control = cu_pkg::ALU_LOOP;
				mux_out_sel = 1'b1;
				rdata_sel = cu_pkg::RDATA_RESULT;
				wr_en_regf = 1'b1; // Decremented count back to R[ra]
			end
			cu_pkg::CMD_JMP: begin
				alu_control = cu_pkg::ALU_PASS_RD2;
				mux_out_sel = 1'b1;
			end
			cu_pkg::CMD_CALL,
			cu_pkg::CMD_INTR: begin
				alu_control = (cmd == cu_pkg::CMD_CALL) ? cu_pkg::ALU_CALL : cu_pkg::ALU_INTR;
				mux_out_sel = (cmd == cu_pkg::CMD_CALL);
				addr_sel = cu_pkg::WA_SP; // SP decremented
				wr_en_regf = 1'b1;
			end
			cu_pkg::CMD_RET,
			cu_pkg::CMD_RTI: begin
				alu_control = (cmd == cu_pkg::CMD_RET) ? cu_pkg::ALU_RET : cu_pkg::ALU_RTI;
				addr_sel = cu_pkg::WA_SP; // SP incremented
				wr_en_regf = 1'b1;
			end
			cu_pkg::CMD_LDI: begin
				alu_control = cu_pkg::ALU_LDI;
				rdata_sel = cu_pkg::RDATA_RESULT;
				addr_sel = cu_pkg::WA_RB;
				wr_en_regf = 1'b1;
			end
			cu_pkg::CMD_STI: alu_control = cu_pkg::ALU_STI;
			cu_pkg::CMD_LDM: begin
				alu_control = cu_pkg::ALU_LDM;
				mux_out_sel = 1'b1;
				rdata_sel = cu_pkg::RDATA_IMM; // Second byte is the value
				addr_sel = cu_pkg::WA_OLD_RB;
				wr_en_regf = 1'b1;
			end
			cu_pkg::CMD_LDD: begin
				alu_control = cu_pkg::ALU_LDD;
				rdata_sel = cu_pkg::RDATA_RESULT;
				addr_sel = cu_pkg::WA_OLD_RB;
				wr_en_regf = 1'b1;
			end
			cu_pkg::CMD_STD: begin
				alu_control = cu_pkg::ALU_STD;
				rd2_sel = 1'b1; // Read port 2 addressed by old_rb
			end
			default: begin
			end
		endcase
	end

endmodule

// File: source/branch_resolver.sv
`timescale 1ns/1ps

module branch_resolver (
	input cu_pkg::cmd_e cmd,
	input logic [cu_pkg::FLAGS_W-1:0] flags,
	output cu_pkg::pc_sel_e pc_sel,
	output logic taken,
	output logic is_ret
);

	always_comb begin
		taken = 1'b0;
		is_ret = 1'b0;
		pc_sel = cu_pkg::PC_INC;
		case (cmd)
			cu_pkg::CMD_JZ: taken = flags[cu_pkg::FLAG_Z];
			cu_pkg::CMD_JN: taken = flags[cu_pkg::FLAG_N];
			cu_pkg::CMD_JC: taken = flags[cu_pkg::FLAG_C];
			cu_pkg::CMD_JV: taken = flags[cu_pkg::FLAG_V];
			cu_pkg::CMD_LOOP: taken = flags[cu_pkg::FLAG_Z]; // Taken while Z is set
			cu_pkg::CMD_JMP,
			cu_pkg::CMD_CALL: taken = 1'b1;
			default: taken = 1'b0;
		endcase

		if (taken) begin
			pc_sel = cu_pkg::PC_JUMP; // Target is R[rb] through the ALU
		end

		case (cmd)
			cu_pkg::CMD_RET,
			cu_pkg::CMD_RTI: begin
				pc_sel = cu_pkg::PC_JUMP; // Target popped from the stack
				is_ret = 1'b1;
			end
			cu_pkg::CMD_INTR: pc_sel = cu_pkg::PC_INTR_VEC;
			cu_pkg::CMD_RESET: pc_sel = cu_pkg::PC_RESET_VEC;
			default: begin
			end
		endcase
	end

endmodule

// File: source/instr_classifier.sv
`timescale 1ns/1ps

module instr_classifier (
	input logic rst,
	input logic intr_in,
	input cu_pkg::state_e phase,
	input logic [cu_pkg::INSTR_W-1:0] opcode,
	input logic [cu_pkg::INSTR_W-1:0] held_byte,
	output cu_pkg::cmd_e cmd
);

	logic [cu_pkg::INSTR_W-1:0] sel_byte;
	cu_pkg::opcode_e major;
	logic [cu_pkg::REG_SEL_W-1:0] ra; // Also the sub-opcode field

	assign sel_byte = (phase == cu_pkg::SECOND_BYTE) ? held_byte : opcode;
	assign major = cu_pkg::opcode_e'(sel_byte[7:4]);
	assign ra = sel_byte[3:2];

	always_comb begin
		cmd = cu_pkg::CMD_NOP;
		if (!rst) begin
			cmd = cu_pkg::CMD_RESET; // Selects the reset vector
		end else if (phase == cu_pkg::IDLE && intr_in) begin
			cmd = cu_pkg::CMD_INTR;
		end else if (phase == cu_pkg::SECOND_BYTE) begin
			case (ra)
				2'd0: cmd = cu_pkg::CMD_LDM;
				2'd1: cmd = cu_pkg::CMD_LDD;
				2'd2: cmd = cu_pkg::CMD_STD;
				default: cmd = cu_pkg::CMD_NOP;
			endcase
		end else begin
			case (major)
				cu_pkg::OP_NOP: cmd = cu_pkg::CMD_NOP;
				cu_pkg::OP_MOV: cmd = cu_pkg::CMD_MOV;
				cu_pkg::OP_ADD: cmd = cu_pkg::CMD_ADD;
				cu_pkg::OP_SUB: cmd = cu_pkg::CMD_SUB;
				cu_pkg::OP_AND: cmd = cu_pkg::CMD_AND;
				cu_pkg::OP_OR: cmd = cu_pkg::CMD_OR;
				cu_pkg::OP_ROT: begin
					case (ra)
						2'd0: cmd = cu_pkg::CMD_RLC;
						2'd1: cmd = cu_pkg::CMD_RRC;
						2'd2: cmd = cu_pkg::CMD_SETC;
						default: cmd = cu_pkg::CMD_CLRC;
					endcase
				end
				cu_pkg::OP_STACK: begin
					case (ra)
						2'd0: cmd = cu_pkg::CMD_PUSH;
						2'd1: cmd = cu_pkg::CMD_POP;
						default: cmd = cu_pkg::CMD_IO; // OUT and IN
					endcase
				end
				cu_pkg::OP_UNARY: begin
					case (ra)
						2'd0: cmd = cu_pkg::CMD_NOT;
						2'd1: cmd = cu_pkg::CMD_NEG;
						2'd2: cmd = cu_pkg::CMD_INC;
						default: cmd = cu_pkg::CMD_DEC;
					endcase
				end
				cu_pkg::OP_JCOND: begin
					case (ra)
						2'd0: cmd = cu_pkg::CMD_JZ;
						2'd1: cmd = cu_pkg::CMD_JN;
						2'd2: cmd = cu_pkg::CMD_JC;
						default: cmd = cu_pkg::CMD_JV;
					endcase
				end
				cu_pkg::OP_LOOP: cmd = cu_pkg::CMD_LOOP;
				cu_pkg::OP_JUMP: begin
					case (ra)
						2'd0: cmd = cu_pkg::CMD_JMP;
						2'd1: cmd = cu_pkg::CMD_CALL;
						2'd2: cmd = cu_pkg::CMD_RET;
						default: cmd = cu_pkg::CMD_RTI;
					endcase
				end
				cu_pkg::OP_TWO_BYTE: cmd = cu_pkg::CMD_FETCH2; // Wait for the second byte
				cu_pkg::OP_LDI: cmd = cu_pkg::CMD_LDI;
				cu_pkg::OP_STI: cmd = cu_pkg::CMD_STI;
				default: cmd = cu_pkg::CMD_NOP; // Opcode 15 unused
			endcase
		end
	end

endmodule

// File: source/instr_sequencer.sv
`timescale 1ns/1ps

module instr_sequencer (
	input logic clk,
	input logic rst,
	input logic [cu_pkg::INSTR_W-1:0] opcode,
	input logic intr_in,
	output cu_pkg::state_e phase,
	output logic [cu_pkg::INSTR_W-1:0] held_byte,
	output logic [cu_pkg::REG_SEL_W-1:0] old_rb
);

	logic capture; // First byte of a two-byte instruction seen
	cu_pkg::state_e next_phase;

	// Interrupt in IDLE wins over the two-byte group
	assign capture = (phase == cu_pkg::IDLE) && !intr_in &&
		(opcode[7:4] == cu_pkg::OP_TWO_BYTE);

	always_comb begin
		case (phase)
			cu_pkg::IDLE: next_phase = capture ? cu_pkg::SECOND_BYTE : cu_pkg::IDLE;
			cu_pkg::SECOND_BYTE: next_phase = cu_pkg::IDLE; // Always one extra cycle
			default: next_phase = cu_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			phase <= cu_pkg::IDLE;
			held_byte <= '0;
		end else begin
			phase <= next_phase;
			if (capture) begin
				held_byte <= opcode; // Keep the whole first byte
			end
		end
	end

	// Destination of LDM/LDD and source of STD
	assign old_rb = (phase == cu_pkg::SECOND_BYTE) ?
		held_byte[cu_pkg::REG_SEL_W-1:0] : '0;

endmodule

// File: source/cu_pkg.sv
package cu_pkg;

	localparam int INSTR_W = 8; // Instruction byte
	localparam int REG_SEL_W = 2; // ra and rb fields
	localparam int ALU_CTRL_W = 6;
	localparam int FLAGS_W = 4; // {Z, N, C, V} from msb down
	localparam int CMD_W = 6; // 34 decoded commands need six bits

	localparam int FLAG_Z = 3;
	localparam int FLAG_N = 2;
	localparam int FLAG_C = 1;
	localparam int FLAG_V = 0;

	typedef enum logic [1:0] {
		IDLE = 2'd0,
		SECOND_BYTE = 2'd1 // Held byte drives decode
	} state_e;

	// Major opcode in the upper nibble of the byte
	typedef enum logic [3:0] {
		OP_NOP = 4'd0, OP_MOV = 4'd1, OP_ADD = 4'd2, OP_SUB = 4'd3,
		OP_AND = 4'd4, OP_OR = 4'd5,
		OP_ROT = 4'd6, // RLC, RRC, SETC, CLRC
		OP_STACK = 4'd7, // PUSH, POP, OUT, IN
		OP_UNARY = 4'd8, // NOT, NEG, INC, DEC
		OP_JCOND = 4'd9, // JZ, JN, JC, JV
		OP_LOOP = 4'd10,
		OP_JUMP = 4'd11, // JMP, CALL, RET, RTI
		OP_TWO_BYTE = 4'd12, // LDM, LDD, STD
		OP_LDI = 4'd13,
		OP_STI = 4'd14
	} opcode_e;

	typedef enum logic [CMD_W-1:0] {
		CMD_NOP, CMD_MOV, CMD_ADD, CMD_SUB, CMD_AND, CMD_OR,
		CMD_RLC, CMD_RRC, CMD_SETC, CMD_CLRC,
		CMD_PUSH, CMD_POP,
		CMD_NOT, CMD_NEG, CMD_INC, CMD_DEC,
		CMD_JZ, CMD_JN, CMD_JC, CMD_JV, CMD_LOOP,
		CMD_JMP, CMD_CALL, CMD_RET, CMD_RTI,
		CMD_LDI, CMD_STI,
		CMD_FETCH2, // First byte of LDM/LDD/STD
		CMD_LDM, CMD_LDD, CMD_STD,
		CMD_INTR, CMD_RESET,
		CMD_IO // IN/OUT, no port logic behind it
	} cmd_e;

	typedef enum logic [ALU_CTRL_W-1:0] {
		ALU_NOP = 6'd0, ALU_MOV = 6'd1, ALU_ADD = 6'd2, ALU_SUB = 6'd3,
		ALU_AND = 6'd4, ALU_OR = 6'd5,
		ALU_SETC = 6'd8, ALU_CLRC = 6'd9,
		ALU_ROT_L = 6'd10, // Also PUSH
		ALU_ROT_R = 6'd11, // Also POP
		ALU_NOT = 6'd14, ALU_NEG = 6'd15, ALU_INC = 6'd16, ALU_DEC = 6'd17,
		ALU_JZ = 6'd18, ALU_JN = 6'd19, ALU_JC = 6'd20, ALU_JV = 6'd21,
		ALU_LOOP = 6'd22,
		ALU_PASS_RD2 = 6'd23, // Jump target from R[rb]
		ALU_CALL = 6'd24, ALU_RET = 6'd25, ALU_RTI = 6'd26,
		ALU_LDM = 6'd27, ALU_LDD = 6'd28, ALU_STD = 6'd29,
		ALU_LDI = 6'd30, ALU_STI = 6'd31,
		ALU_INTR = 6'd32
	} alu_op_e;

	typedef enum logic [1:0] {
		PC_INC = 2'd0, PC_RESET_VEC = 2'd1, PC_INTR_VEC = 2'd2, PC_JUMP = 2'd3
	} pc_sel_e;

	// Register file write address
	typedef enum logic [1:0] {
		WA_RA = 2'd0, WA_RB = 2'd1, WA_SP = 2'd2, WA_OLD_RB = 2'd3
	} addr_sel_e;

	// Register file write data
	typedef enum logic [1:0] {
		RDATA_SP = 2'd0, RDATA_RESULT = 2'd2, RDATA_IMM = 2'd3
	} rdata_sel_e;

	typedef enum logic [1:0] {
		DA_REG = 2'd0, DA_SP = 2'd1, DA_SP_INC = 2'd2, DA_EA = 2'd3
	} dmem_a_sel_e;

	typedef enum logic [1:0] {
		WD_ZERO = 2'd0, WD_REG = 2'd1, WD_PC_NEXT = 2'd2, WD_PC = 2'd3
	} dmem_wd_sel_e;

endpackage
